/* src/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ************************************************************************
// widths and memory sizes
// ************************************************************************

`define CPU_DBITS          32
`define CPU_REGNO_BITS     4
`define CPU_IMM_BITS       16
`define CPU_IMEM_WORDS     4096
`define CPU_DMEM_WORDS     4096
// word index into either memory, byte address bits 13..2
`define CPU_MEM_INDEX_BITS 12

// ************************************************************************
// reset PC and memory-mapped I/O
// ************************************************************************

`define CPU_START_PC       32'h0000_0100
`define CPU_ADDR_HEX       32'hFFFF_F000
`define CPU_ADDR_KEY       32'hFFFF_F080
`define CPU_HEX_BITS       24
`define CPU_HEX_RESET      24'hFEDEAD
`define CPU_KEY_BITS       4

// primary opcodes, bits 31..26
`define CPU_OP1_ALUR       6'b000000
`define CPU_OP1_BEQ        6'b001000
`define CPU_OP1_BLT        6'b001001
`define CPU_OP1_BLE        6'b001010
`define CPU_OP1_BNE        6'b001011
`define CPU_OP1_JAL        6'b001100
`define CPU_OP1_LW         6'b010010
`define CPU_OP1_SW         6'b011010
`define CPU_OP1_ADDI       6'b100000
`define CPU_OP1_ANDI       6'b100100
`define CPU_OP1_ORI        6'b100101
`define CPU_OP1_XORI       6'b100110

// secondary opcodes, bits 25..18, only under ALUR
`define CPU_OP2_EQ         8'b00001000
`define CPU_OP2_LT         8'b00001001
`define CPU_OP2_LE         8'b00001010
`define CPU_OP2_NE         8'b00001011
`define CPU_OP2_ADD        8'b00100000
`define CPU_OP2_AND        8'b00100100
`define CPU_OP2_OR         8'b00100101
`define CPU_OP2_XOR        8'b00100110
`define CPU_OP2_SUB        8'b00101000
`define CPU_OP2_NAND       8'b00101100
`define CPU_OP2_NOR        8'b00101101
`define CPU_OP2_NXOR       8'b00101110
`define CPU_OP2_RSHF       8'b00110000
`define CPU_OP2_LSHF       8'b00110001

`endif

/* src/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

  // ************************************************************************
  // datapath types
  // ************************************************************************

  // one data word, also used for byte addresses and the PC
  typedef logic [`CPU_DBITS-1:0] word_t;

  // register number, sixteen registers
  typedef logic [`CPU_REGNO_BITS-1:0] regno_t;

  // ************************************************************************
  // instruction fields
  // ************************************************************************

  // primary opcode, bits 31..26
  typedef logic [5:0] op1_t;

  // secondary opcode, bits 25..18
  typedef logic [7:0] op2_t;

  // raw immediate, bits 23..8, sign-extended in decode
  typedef logic [`CPU_IMM_BITS-1:0] imm_t;

  // memories and display
  // word index into instruction or data memory
  typedef logic [`CPU_MEM_INDEX_BITS-1:0] mem_index_t;

  // value shown on the six-digit display
  typedef logic [`CPU_HEX_BITS-1:0] hex_t;

endpackage

/* src/fetch_stage.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       stall,
  input  logic       redirect,
  input  word_t      redirect_pc,
  input  logic       imem_load_en,
  input  mem_index_t imem_load_index,
  input  word_t      imem_load_data,
  output word_t      inst_fd,
  output word_t      pc_fd
);

  word_t      pc;
  mem_index_t fetch_index;
  word_t      imem [0:`CPU_IMEM_WORDS-1];

  // word index of the current PC
  assign fetch_index = pc[`CPU_MEM_INDEX_BITS+1:2];

  // program load port, only driven while the core is held in reset
  always_ff @(posedge clk) begin
    if (imem_load_en) begin
      imem[imem_load_index] <= imem_load_data;
    end
  end

  // next PC: redirect from execute wins over a decode stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= `CPU_START_PC;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  // fetch latch, all-ones word is a bubble (no opcode matches it)
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      inst_fd <= '1;
    end else if (redirect) begin
      inst_fd <= '1;
    end else if (!stall) begin
      inst_fd <= imem[fetch_index];
    end
  end

  // pc of the latched word, held together with it on a stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_fd <= pc;
    end
  end

  // loading is only safe while the pipeline is frozen
  a_load_only_in_reset: assert property (@(posedge clk) !reset |-> !imem_load_en)
    else $error("instruction memory written while the core is running");

endmodule

/* src/register_file.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module register_file import cpu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  regno_t rs,
  input  regno_t rt,
  output word_t  rs_value,
  output word_t  rt_value,
  input  logic   wb_en,
  input  regno_t wb_regno,
  input  word_t  wb_data
);

  word_t regs [0:(1 << `CPU_REGNO_BITS)-1];

  // single write port, written at the end of writeback
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < (1 << `CPU_REGNO_BITS); i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_regno] <= wb_data;
    end
  end

  // read ports
  // a register being written this cycle is passed straight through,
  // so decode never has to wait an extra cycle for writeback
  assign rs_value = (wb_en && (wb_regno == rs)) ? wb_data : regs[rs];
  assign rt_value = (wb_en && (wb_regno == rt)) ? wb_data : regs[rt];

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module decode_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  inst_fd,
  input  word_t  pc_fd,
  output regno_t rs,
  output regno_t rt,
  input  word_t  rs_value,
  input  word_t  rt_value,
  input  logic   redirect,
  input  logic   ex_wr_reg,
  input  logic   mem_wr_reg,
  input  regno_t ex_wregno,
  input  regno_t mem_wregno,
  output logic   stall,
  output op1_t   op1,
  output op2_t   op2,
  output word_t  a,
  output word_t  b,
  output word_t  imm,
  output word_t  pc_de,
  output regno_t wregno,
  output logic   wr_reg,
  output logic   rd_mem,
  output logic   wr_mem,
  output logic   branch,
  output logic   jump
);

  op1_t   op1_w;
  op2_t   op2_w;
  imm_t   imm_w;
  regno_t rd_w;
  regno_t wregno_w;
  logic   is_alur, is_alui, is_lw, is_sw, is_br, is_jal;
  logic   uses_rs, uses_rt, wr_reg_w;
  logic   hazard_ex, hazard_mem;

  // ************************************************************************
  // field extraction and opcode classes
  // ************************************************************************

  // imm overlaps op2 and rd, each class only looks at its own fields
  assign op1_w = inst_fd[31:26];
  assign op2_w = inst_fd[25:18];
  assign imm_w = inst_fd[23:8];
  assign rd_w  = inst_fd[11:8];
  assign rs    = inst_fd[7:4];
  assign rt    = inst_fd[3:0];

  assign is_alur = (op1_w == `CPU_OP1_ALUR);
  assign is_alui = (op1_w == `CPU_OP1_ADDI) || (op1_w == `CPU_OP1_ANDI) ||
                   (op1_w == `CPU_OP1_ORI)  || (op1_w == `CPU_OP1_XORI);
  assign is_lw   = (op1_w == `CPU_OP1_LW);
  assign is_sw   = (op1_w == `CPU_OP1_SW);
  assign is_br   = (op1_w == `CPU_OP1_BEQ) || (op1_w == `CPU_OP1_BLT) ||
                   (op1_w == `CPU_OP1_BLE) || (op1_w == `CPU_OP1_BNE);
  assign is_jal  = (op1_w == `CPU_OP1_JAL);

  // which sources are really read; a bubble reads nothing
  assign uses_rs = is_alur || is_alui || is_lw || is_sw || is_br || is_jal;
  assign uses_rt = is_alur || is_sw || is_br;

  // destination is rd for ALUR, rt for immediates, LW and the JAL link
  assign wr_reg_w = is_alur || is_alui || is_lw || is_jal;
  assign wregno_w = is_alur ? rd_w : rt;

  // ************************************************************************
  // RAW hazard against execute and memory
  // ************************************************************************

  assign hazard_ex  = ex_wr_reg &&
                      ((uses_rs && (ex_wregno == rs)) || (uses_rt && (ex_wregno == rt)));
  assign hazard_mem = mem_wr_reg &&
                      ((uses_rs && (mem_wregno == rs)) || (uses_rt && (mem_wregno == rt)));
  // a writer already in writeback is covered by the register file bypass
  assign stall = hazard_ex || hazard_mem;

  // decode latch, control part
  // stall or redirect sends a bubble into execute
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_reg <= 1'b0;
      rd_mem <= 1'b0;
      wr_mem <= 1'b0;
      branch <= 1'b0;
      jump   <= 1'b0;
    end else if (redirect || stall) begin
      wr_reg <= 1'b0;
      rd_mem <= 1'b0;
      wr_mem <= 1'b0;
      branch <= 1'b0;
      jump   <= 1'b0;
    end else begin
      wr_reg <= wr_reg_w;
      rd_mem <= is_lw;
      wr_mem <= is_sw;
      branch <= is_br;
      jump   <= is_jal;
    end
  end

  // decode latch, payload part
  always_ff @(posedge clk) begin
    op1    <= op1_w;
    op2    <= op2_w;
    a      <= rs_value;
    b      <= rt_value;
    imm    <= {{(`CPU_DBITS-`CPU_IMM_BITS){imm_w[`CPU_IMM_BITS-1]}}, imm_w};
    pc_de  <= pc_fd;
    wregno <= wregno_w;
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module execute_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  op1_t   op1,
  input  op2_t   op2,
  input  word_t  a,
  input  word_t  b,
  input  word_t  imm,
  input  word_t  pc_de,
  input  regno_t wregno,
  input  logic   wr_reg,
  input  logic   rd_mem,
  input  logic   wr_mem,
  input  logic   branch,
  input  logic   jump,
  output logic   redirect,
  output word_t  redirect_pc,
  output logic   ex_wr_reg,
  output regno_t ex_wregno,
  output word_t  alu_result,
  output word_t  store_data,
  output regno_t wregno_em,
  output logic   wr_reg_em,
  output logic   rd_mem_em,
  output logic   wr_mem_em
);

  word_t pc_plus4;
  word_t imm_x4;
  word_t alu_w;
  logic  taken;

  assign pc_plus4 = pc_de + 32'd4;
  assign imm_x4   = imm << 2;

  // branch condition, signed compare of rs against rt
  always_comb begin
    case (op1)
      `CPU_OP1_BEQ: taken = (a == b);
      `CPU_OP1_BLT: taken = ($signed(a) < $signed(b));
      `CPU_OP1_BLE: taken = ($signed(a) <= $signed(b));
      `CPU_OP1_BNE: taken = (a != b);
      default:      taken = 1'b0;
    endcase
  end

  // ************************************************************************
  // ALU
  // ************************************************************************

  always_comb begin
    case (op1)
      `CPU_OP1_ALUR: begin
        case (op2)
          `CPU_OP2_EQ:   alu_w = word_t'(a == b);
          `CPU_OP2_LT:   alu_w = word_t'($signed(a) < $signed(b));
          `CPU_OP2_LE:   alu_w = word_t'($signed(a) <= $signed(b));
          `CPU_OP2_NE:   alu_w = word_t'(a != b);
          `CPU_OP2_ADD:  alu_w = a + b;
          `CPU_OP2_AND:  alu_w = a & b;
          `CPU_OP2_OR:   alu_w = a | b;
          `CPU_OP2_XOR:  alu_w = a ^ b;
          `CPU_OP2_SUB:  alu_w = a - b;
          `CPU_OP2_NAND: alu_w = ~(a & b);
          `CPU_OP2_NOR:  alu_w = ~(a | b);
          `CPU_OP2_NXOR: alu_w = ~(a ^ b);
          // shifts take the low 5 bits of rt, right shift keeps the sign
          `CPU_OP2_RSHF: alu_w = word_t'($signed(a) >>> b[4:0]);
          `CPU_OP2_LSHF: alu_w = a << b[4:0];
          default:       alu_w = '0;
        endcase
      end
      // LW and SW share the adder for address generation
      `CPU_OP1_ADDI, `CPU_OP1_LW, `CPU_OP1_SW: alu_w = a + imm;
      `CPU_OP1_ANDI: alu_w = a & imm;
      `CPU_OP1_ORI:  alu_w = a | imm;
      `CPU_OP1_XORI: alu_w = a ^ imm;
      // link value for JAL
      `CPU_OP1_JAL:  alu_w = pc_plus4;
      default:       alu_w = '0;
    endcase
  end

  // redirect for a taken branch or any JAL, computed off the decode latch
  assign redirect    = (branch && taken) || jump;
  assign redirect_pc = jump ? (a + imm_x4) : (pc_plus4 + imm_x4);

  // destination of the instruction now in execute, for the hazard check
  assign ex_wr_reg = wr_reg;
  assign ex_wregno = wregno;

  // execute latch, control part
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_reg_em <= 1'b0;
      rd_mem_em <= 1'b0;
      wr_mem_em <= 1'b0;
    end else begin
      wr_reg_em <= wr_reg;
      rd_mem_em <= rd_mem;
      wr_mem_em <= wr_mem;
    end
  end

  // execute latch, payload part
  always_ff @(posedge clk) begin
    alu_result <= alu_w;
    store_data <= b;
    wregno_em  <= wregno;
  end

  // decode must never mark one instruction as both kinds of control flow
  a_branch_xor_jump: assert property (@(posedge clk) disable iff (reset) !(branch && jump))
    else $error("branch and jump flags set together in execute");

endmodule

/* src/memory_stage.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module memory_stage import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  word_t                    alu_result,
  input  word_t                    store_data,
  input  regno_t                   wregno_em,
  input  logic                     wr_reg_em,
  input  logic                     rd_mem_em,
  input  logic                     wr_mem_em,
  input  logic [`CPU_KEY_BITS-1:0] key,
  output logic                     mem_wr_reg,
  output regno_t                   mem_wregno,
  output logic                     wb_en,
  output regno_t                   wb_regno,
  output word_t                    wb_data,
  output hex_t                     hex_value,
  output logic                     hex_write
);

  mem_index_t dmem_index;
  logic       is_hex;
  logic       is_key;
  word_t      load_data;
  word_t      dmem [0:`CPU_DMEM_WORDS-1];

  // address decode, alu_result is the byte address for LW and SW
  assign dmem_index = alu_result[`CPU_MEM_INDEX_BITS+1:2];
  assign is_hex     = (alu_result == `CPU_ADDR_HEX);
  assign is_key     = (alu_result == `CPU_ADDR_KEY);

  // keys are active low, software sees a pressed key as 1
  assign load_data = is_key ? {{(`CPU_DBITS-`CPU_KEY_BITS){1'b0}}, ~key} : dmem[dmem_index];

  // destination in memory stage, for the hazard check
  assign mem_wr_reg = wr_reg_em;
  assign mem_wregno = wregno_em;

  // ************************************************************************
  // data memory and HEX register
  // ************************************************************************

  // HEX stores go to the display register, not to the RAM
  always_ff @(posedge clk) begin
    if (wr_mem_em && !is_hex) begin
      dmem[dmem_index] <= store_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex_value <= `CPU_HEX_RESET;
      hex_write <= 1'b0;
    end else begin
      // pulse lines up with the new display value
      hex_write <= wr_mem_em && is_hex;
      if (wr_mem_em && is_hex) begin
        hex_value <= store_data[`CPU_HEX_BITS-1:0];
      end
    end
  end

  // writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_en <= 1'b0;
    end else begin
      wb_en <= wr_reg_em;
    end
  end

  always_ff @(posedge clk) begin
    wb_regno <= wregno_em;
    wb_data  <= rd_mem_em ? load_data : alu_result;
  end

  // LW and SW are separate opcodes, both flags at once means a decode fault
  a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(rd_mem_em && wr_mem_em))
    else $error("load and store flags set together in memory stage");

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_top import cpu_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`CPU_KEY_BITS-1:0] key,
  input  logic                     imem_load_en,
  input  mem_index_t               imem_load_index,
  input  word_t                    imem_load_data,
  output hex_t                     hex_value,
  output logic                     hex_write
);

  // ************************************************************************
  // inter-stage wires
  // ************************************************************************

  // fetch and decode
  word_t  inst_fd, pc_fd;
  logic   stall;

  // register file read side
  regno_t rs, rt;
  word_t  rs_value, rt_value;

  // decode latch
  op1_t   op1;
  op2_t   op2;
  word_t  a, b, imm, pc_de;
  regno_t wregno;
  logic   wr_reg, rd_mem, wr_mem, branch, jump;

  // execute outputs
  logic   redirect, ex_wr_reg;
  word_t  redirect_pc;
  regno_t ex_wregno;

  // execute latch
  word_t  alu_result, store_data;
  regno_t wregno_em;
  logic   wr_reg_em, rd_mem_em, wr_mem_em;

  // memory and writeback
  logic   mem_wr_reg, wb_en;
  regno_t mem_wregno, wb_regno;
  word_t  wb_data;

  fetch_stage fetch_stage_i (
    .clk, .reset, .stall, .redirect, .redirect_pc,
    .imem_load_en, .imem_load_index, .imem_load_data,
    .inst_fd, .pc_fd
  );

  register_file register_file_i (
    .clk, .reset, .rs, .rt, .rs_value, .rt_value,
    .wb_en, .wb_regno, .wb_data
  );

  decode_stage decode_stage_i (
    .clk, .reset, .inst_fd, .pc_fd, .rs, .rt, .rs_value, .rt_value,
    .redirect, .ex_wr_reg, .mem_wr_reg, .ex_wregno, .mem_wregno, .stall,
    .op1, .op2, .a, .b, .imm, .pc_de, .wregno,
    .wr_reg, .rd_mem, .wr_mem, .branch, .jump
  );

  execute_stage execute_stage_i (
    .clk, .reset, .op1, .op2, .a, .b, .imm, .pc_de, .wregno,
    .wr_reg, .rd_mem, .wr_mem, .branch, .jump,
    .redirect, .redirect_pc, .ex_wr_reg, .ex_wregno,
    .alu_result, .store_data, .wregno_em, .wr_reg_em, .rd_mem_em, .wr_mem_em
  );

  memory_stage memory_stage_i (
    .clk, .reset, .alu_result, .store_data, .wregno_em,
    .wr_reg_em, .rd_mem_em, .wr_mem_em, .key,
    .mem_wr_reg, .mem_wregno, .wb_en, .wb_regno, .wb_data,
    .hex_value, .hex_write
  );

endmodule

/* test/cpu_programs.svh */
// ************************************************************************
// test program table
// ************************************************************************

localparam int NUM_TESTS = 7;
localparam int MAX_WORDS = 20;

word_t      prog_mem [NUM_TESTS][MAX_WORDS];
int         prog_len [NUM_TESTS];
hex_t       exp_hex [NUM_TESTS];
int         exp_pulses [NUM_TESTS];
logic [3:0] key_val [NUM_TESTS];
string      test_name [NUM_TESTS];

// register ALU form, rd 11..8, rs 7..4, rt 3..0
function automatic word_t enc_r(op2_t op2, regno_t rd, regno_t rs, regno_t rt);
  return {`CPU_OP1_ALUR, op2, 6'b0, rd, rs, rt};
endfunction

// immediate form, imm 23..8; rt is the destination, link or store data
function automatic word_t enc_i(op1_t op1, regno_t rt, regno_t rs, imm_t imm);
  return {op1, 2'b0, imm, rs, rt};
endfunction

task automatic emit(int t, word_t w);
  prog_mem[t][prog_len[t]] = w;
  prog_len[t]++;
endtask

// result to HEX, then spin on a branch to itself
task automatic finish_prog(int t, regno_t r);
  emit(t, enc_i(`CPU_OP1_ADDI, 4'd15, 4'd0, 16'hF000));
  emit(t, enc_i(`CPU_OP1_SW, r, 4'd15, 16'h0000));
  emit(t, enc_i(`CPU_OP1_BEQ, 4'd0, 4'd0, 16'hFFFF));
endtask

task automatic build_programs(inout int seed);
  for (int t = 0; t < NUM_TESTS; t++) begin
    prog_len[t]   = 0;
    exp_pulses[t] = 1;
    key_val[t]    = 4'($random(seed));
  end
  // signed compares folded into bits 0..3
  test_name[0] = "compare";
  emit(0, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'h0007));
  emit(0, enc_i(`CPU_OP1_ADDI, 4'd2, 4'd0, 16'hFFFD));
  emit(0, enc_r(`CPU_OP2_LT, 4'd3, 4'd2, 4'd1));
  emit(0, enc_r(`CPU_OP2_LE, 4'd4, 4'd2, 4'd1));
  emit(0, enc_r(`CPU_OP2_EQ, 4'd5, 4'd1, 4'd1));
  emit(0, enc_r(`CPU_OP2_NE, 4'd6, 4'd1, 4'd2));
  emit(0, enc_r(`CPU_OP2_ADD, 4'd4, 4'd4, 4'd4));
  emit(0, enc_r(`CPU_OP2_ADD, 4'd5, 4'd5, 4'd5));
  emit(0, enc_r(`CPU_OP2_ADD, 4'd5, 4'd5, 4'd5));
  emit(0, enc_r(`CPU_OP2_ADD, 4'd6, 4'd6, 4'd6));
  emit(0, enc_r(`CPU_OP2_ADD, 4'd6, 4'd6, 4'd6));
  emit(0, enc_r(`CPU_OP2_ADD, 4'd6, 4'd6, 4'd6));
  emit(0, enc_r(`CPU_OP2_OR, 4'd3, 4'd3, 4'd4));
  emit(0, enc_r(`CPU_OP2_OR, 4'd3, 4'd3, 4'd5));
  emit(0, enc_r(`CPU_OP2_OR, 4'd3, 4'd3, 4'd6));
  finish_prog(0, 4'd3);
  exp_hex[0] = 24'h00000F;
  // bitwise and add/sub mix
  test_name[1] = "logic";
  emit(1, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'h0F0F));
  emit(1, enc_i(`CPU_OP1_ADDI, 4'd2, 4'd0, 16'h00FF));
  emit(1, enc_r(`CPU_OP2_NAND, 4'd3, 4'd1, 4'd2));
  emit(1, enc_r(`CPU_OP2_NOR, 4'd4, 4'd1, 4'd2));
  emit(1, enc_r(`CPU_OP2_NXOR, 4'd5, 4'd1, 4'd2));
  emit(1, enc_r(`CPU_OP2_AND, 4'd7, 4'd1, 4'd2));
  emit(1, enc_r(`CPU_OP2_OR, 4'd8, 4'd1, 4'd2));
  emit(1, enc_r(`CPU_OP2_ADD, 4'd6, 4'd3, 4'd4));
  emit(1, enc_r(`CPU_OP2_SUB, 4'd6, 4'd6, 4'd5));
  emit(1, enc_r(`CPU_OP2_ADD, 4'd6, 4'd6, 4'd7));
  emit(1, enc_r(`CPU_OP2_XOR, 4'd6, 4'd6, 4'd8));
  finish_prog(1, 4'd6);
  exp_hex[1] = 24'hFFF00F;
  // shift amount 44 uses only its low 5 bits
  // sign fill reaches bits 20..23 of the display
  test_name[2] = "shift";
  emit(2, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'hFF00));
  emit(2, enc_i(`CPU_OP1_ADDI, 4'd2, 4'd0, 16'h002C));
  emit(2, enc_r(`CPU_OP2_RSHF, 4'd3, 4'd1, 4'd2));
  emit(2, enc_i(`CPU_OP1_ADDI, 4'd4, 4'd0, 16'h0123));
  emit(2, enc_r(`CPU_OP2_LSHF, 4'd5, 4'd4, 4'd2));
  emit(2, enc_r(`CPU_OP2_XOR, 4'd6, 4'd3, 4'd5));
  finish_prog(2, 4'd6);
  exp_hex[2] = 24'hEDCFFF;
  // sign-extended immediates, upper ones survive into bits 16..23
  test_name[3] = "immediate";
  emit(3, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'hFFFB));
  emit(3, enc_i(`CPU_OP1_ANDI, 4'd2, 4'd1, 16'h8F0F));
  emit(3, enc_i(`CPU_OP1_ORI, 4'd3, 4'd2, 16'h0070));
  emit(3, enc_i(`CPU_OP1_XORI, 4'd4, 4'd3, 16'h7000));
  finish_prog(3, 4'd4);
  exp_hex[3] = 24'hFFFF7B;
  // back-to-back dependences
  test_name[4] = "hazard";
  emit(4, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'h0001));
  emit(4, enc_r(`CPU_OP2_ADD, 4'd1, 4'd1, 4'd1));
  emit(4, enc_r(`CPU_OP2_ADD, 4'd1, 4'd1, 4'd1));
  emit(4, enc_i(`CPU_OP1_ADDI, 4'd2, 4'd1, 16'h0003));
  emit(4, enc_r(`CPU_OP2_SUB, 4'd3, 4'd2, 4'd1));
  emit(4, enc_r(`CPU_OP2_LSHF, 4'd3, 4'd3, 4'd2));
  emit(4, enc_r(`CPU_OP2_ADD, 4'd3, 4'd3, 4'd2));
  finish_prog(4, 4'd3);
  exp_hex[4] = 24'h000187;
  // taken BEQ, not-taken BNE, JAL to word 11, wrong-path stores at 4 and 9
  test_name[5] = "control";
  emit(5, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'h0005));
  emit(5, enc_i(`CPU_OP1_ADDI, 4'd2, 4'd0, 16'h0005));
  emit(5, enc_i(`CPU_OP1_ADDI, 4'd15, 4'd0, 16'hF000));
  emit(5, enc_i(`CPU_OP1_BEQ, 4'd2, 4'd1, 16'h0002));
  emit(5, enc_i(`CPU_OP1_SW, 4'd1, 4'd15, 16'h0000));
  emit(5, enc_i(`CPU_OP1_ADDI, 4'd3, 4'd0, 16'h0111));
  emit(5, enc_i(`CPU_OP1_BNE, 4'd2, 4'd1, 16'h0001));
  emit(5, enc_i(`CPU_OP1_ADDI, 4'd4, 4'd0, 16'h0020));
  emit(5, enc_i(`CPU_OP1_JAL, 4'd5, 4'd0, 16'h004B));
  emit(5, enc_i(`CPU_OP1_SW, 4'd1, 4'd15, 16'h0000));
  emit(5, enc_i(`CPU_OP1_ADDI, 4'd4, 4'd0, 16'h0999));
  emit(5, enc_r(`CPU_OP2_ADD, 4'd6, 4'd4, 4'd5));
  emit(5, enc_r(`CPU_OP2_ADD, 4'd6, 4'd6, 4'd3));
  finish_prog(5, 4'd6);
  exp_hex[5] = 24'h000144;
  // store, reload, then KEY read placed under the shifted word
  test_name[6] = "memory";
  emit(6, enc_i(`CPU_OP1_ADDI, 4'd1, 4'd0, 16'h0040));
  emit(6, enc_i(`CPU_OP1_ADDI, 4'd2, 4'd0, 16'h05A5));
  emit(6, enc_i(`CPU_OP1_SW, 4'd2, 4'd1, 16'h0008));
  emit(6, enc_i(`CPU_OP1_LW, 4'd3, 4'd1, 16'h0008));
  emit(6, enc_i(`CPU_OP1_ADDI, 4'd4, 4'd0, 16'hF080));
  emit(6, enc_i(`CPU_OP1_LW, 4'd5, 4'd4, 16'h0000));
  emit(6, enc_i(`CPU_OP1_ADDI, 4'd7, 4'd0, 16'h000C));
  emit(6, enc_r(`CPU_OP2_LSHF, 4'd3, 4'd3, 4'd7));
  emit(6, enc_r(`CPU_OP2_OR, 4'd3, 4'd3, 4'd5));
  finish_prog(6, 4'd3);
  exp_hex[6] = {20'h5A500, ~key_val[6]};
endtask

/* test/cpu_tb.sv */
`timescale 1ns/1ns
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();

  logic       clk;
  logic       reset;
  logic [3:0] key;
  logic       imem_load_en;
  mem_index_t imem_load_index;
  word_t      imem_load_data;
  hex_t       hex_value;
  logic       hex_write;

  int seed = 6054;
  int errors = 0;
  int passed = 0;

  `include "cpu_programs.svh"

  cpu_top cpu_top_i (
    .clk, .reset, .key, .imem_load_en, .imem_load_index, .imem_load_data,
    .hex_value, .hex_write
  );

  // ************************************************************************
  // clock and watchdog
  // ************************************************************************

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 300 cycles of 4 ns per test
  initial begin
    #(NUM_TESTS * 300 * 4);
    $display("run timed out before all tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // reset held while the program is written, at least 8 cycles
  task automatic load_and_start(int t);
    int base;
    int cycles;
    base   = `CPU_START_PC >> 2;
    cycles = (prog_len[t] > 8) ? prog_len[t] : 8;
    @(negedge clk);
    reset = 1'b1;
    key   = key_val[t];
    for (int i = 0; i < cycles; i++) begin
      imem_load_en    = (i < prog_len[t]);
      imem_load_index = mem_index_t'(base + i);
      imem_load_data  = (i < prog_len[t]) ? prog_mem[t][i] : '1;
      @(negedge clk);
    end
    imem_load_en = 1'b0;
    reset        = 1'b0;
  endtask

  task automatic run_test(int t);
    int seen;
    int extra;
    int cycles;
    int fails_before;
    fails_before = errors;
    seen = 0;
    extra = 0;
    cycles = 0;
    load_and_start(t);
    @(negedge clk);
    // display shows its reset value until the first store
    assert (hex_value == `CPU_HEX_RESET) else begin
      $display("[FAIL] %0t hex_value expected %h got %h",
               $time, `CPU_HEX_RESET, hex_value);
      errors++;
    end
    assert (!hex_write) else begin
      $display("[FAIL] %0t hex_write expected 0 got %b", $time, hex_write);
      errors++;
    end
    while (seen < exp_pulses[t] && cycles < 200) begin
      @(negedge clk);
      cycles++;
      if (hex_write) begin
        seen++;
      end else if (seen == 0) begin
        // no store has retired yet
        assert (hex_value == `CPU_HEX_RESET) else begin
          $display("[FAIL] %0t hex_value expected %h got %h",
                   $time, `CPU_HEX_RESET, hex_value);
          errors++;
        end
      end
    end
    if (seen < exp_pulses[t]) begin
      $display("test %s never wrote the display", test_name[t]);
      errors++;
    end else begin
      assert (hex_value == exp_hex[t]) else begin
        $display("[FAIL] %0t hex_value expected %h got %h", $time, exp_hex[t], hex_value);
        errors++;
      end
    end
    // any further pulse would come from a wrong-path store
    repeat (20) begin
      @(negedge clk);
      if (hex_write) extra++;
    end
    assert (extra == 0) else begin
      $display("[FAIL] %0t hex_write pulses expected %0d got %0d",
               $time, exp_pulses[t], exp_pulses[t] + extra);
      errors++;
    end
    if (errors == fails_before) begin
      passed++;
      $display("test %0d %s: ok (key %h)", t, test_name[t], key_val[t]);
    end else begin
      $display("test %0d %s: failed (key %h)", t, test_name[t], key_val[t]);
    end
  endtask

  initial begin
    reset           = 1'b1;
    key             = 4'hF;
    imem_load_en    = 1'b0;
    imem_load_index = '0;
    imem_load_data  = '0;
    build_programs(seed);
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d of %0d, errors %0d", passed, NUM_TESTS, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+src
+incdir+test
src/cpu_pkg.sv
src/fetch_stage.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_top.sv
test/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpu_tb -o cpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" <<< "$output"; then
  exit 0
fi
exit 1
